//--- verilog/pulse_pair_pkg.sv
package pulse_pair_pkg;

    // ------------------------------------------------------------------------
    // geometry of one sample word
    // ------------------------------------------------------------------------
    localparam int NUM_LANES = 16;

    // pair slots reported per word
    localparam int MAX_PAIRS = 8;

    // cycles from valid_in to the matching valid_out
    localparam int PAIR_LATENCY = 4;

    // ------------------------------------------------------------------------
    // shared types
    // ------------------------------------------------------------------------

    // one bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // lane position inside a word
    typedef logic [3:0] lane_idx_t;

    // crossing or pair count, 0 to 16
    typedef logic [4:0] cross_cnt_t;

    // slot 0 sits in the low nibble
    typedef lane_idx_t [MAX_PAIRS-1:0] pair_lanes_t;

endpackage

//--- verilog/crossing_count.sv
`timescale 1ns/100ps

module crossing_count (
    input  pulse_pair_pkg::lane_mask_t zero_mask,
    input  pulse_pair_pkg::lane_mask_t zero_direction,
    output pulse_pair_pkg::lane_mask_t rise_mask,
    output pulse_pair_pkg::lane_mask_t fall_mask,
    output pulse_pair_pkg::cross_cnt_t rise_cnt,
    output pulse_pair_pkg::cross_cnt_t fall_cnt
);
    import pulse_pair_pkg::*;

    // ------------------------------------------------------------------------
    // direction split
    // ------------------------------------------------------------------------

    // rising crossings open a pulse
    assign rise_mask = zero_mask & zero_direction;

    // falling crossings close it
    assign fall_mask = zero_mask & ~zero_direction;

    // ------------------------------------------------------------------------
    // population counts, shared by fast and slow path
    // ------------------------------------------------------------------------
    always_comb begin
        rise_cnt = '0;
        fall_cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            rise_cnt = rise_cnt + cross_cnt_t'(rise_mask[i]);
            fall_cnt = fall_cnt + cross_cnt_t'(fall_mask[i]);
        end
    end

endmodule

//--- verilog/rank_extract.sv
`timescale 1ns/100ps

module rank_extract (
    input  pulse_pair_pkg::lane_mask_t  mask,
    output pulse_pair_pkg::pair_lanes_t lanes
);
    import pulse_pair_pkg::*;

    // set bits seen below the current lane
    cross_cnt_t seen;

    // ------------------------------------------------------------------------
    // lane of the n-th set bit, lowest lane is rank 0
    // ------------------------------------------------------------------------
    always_comb begin
        seen  = '0;
        lanes = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (mask[i]) begin
                // only the first MAX_PAIRS ranks have a slot
                for (int r = 0; r < MAX_PAIRS; r++) begin
                    if (seen == cross_cnt_t'(r)) begin
                        lanes[r] = lane_idx_t'(i);
                    end
                end
            end
            seen = seen + cross_cnt_t'(mask[i]);
        end
    end

    // absent ranks keep lane 0 from the default above

endmodule

//--- verilog/pending_tracker.sv
`timescale 1ns/100ps

module pending_tracker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  pulse_pair_pkg::lane_mask_t rise_mask,
    input  pulse_pair_pkg::cross_cnt_t rise_cnt,
    input  pulse_pair_pkg::cross_cnt_t fall_cnt,
    output logic                       hold_valid,
    output pulse_pair_pkg::lane_idx_t  hold_lane,
    output logic                       pending_valid_out,
    output pulse_pair_pkg::lane_idx_t  pending_pos_out,
    output logic                       new_pending_out,
    output pulse_pair_pkg::lane_idx_t  new_pending_pos_out
);
    import pulse_pair_pkg::*;

    pair_lanes_t rise_lanes;
    cross_cnt_t  open_cnt;
    cross_cnt_t  new_rank;
    logic        new_start;
    logic        keep_start;
    lane_idx_t   new_lane;

    rank_extract u_rise_rank (
        .mask  (rise_mask),
        .lanes (rise_lanes)
    );

    // ------------------------------------------------------------------------
    // pending rule settles within one cycle
    // ------------------------------------------------------------------------

    // rising crossings still looking for an end including the held start
    assign open_cnt   = rise_cnt + cross_cnt_t'(hold_valid);
    assign new_start  = (open_cnt > fall_cnt) && (rise_cnt != '0);
    assign keep_start = hold_valid && (fall_cnt == '0);

    // first falling edge goes to the held start if there is one
    assign new_rank = fall_cnt - cross_cnt_t'(hold_valid);

    always_comb begin
        new_lane = '0;
        for (int r = 0; r < MAX_PAIRS; r++) begin
            if (new_rank == cross_cnt_t'(r)) begin
                new_lane = rise_lanes[r];
            end
        end
    end

    // state only moves on valid words
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid          <= 1'b0;
            hold_lane           <= '0;
            pending_valid_out   <= 1'b0;
            pending_pos_out     <= '0;
            new_pending_out     <= 1'b0;
            new_pending_pos_out <= '0;
        end else if (valid_in) begin
            hold_valid          <= new_start || keep_start;
            hold_lane           <= new_start ? new_lane : (keep_start ? hold_lane : '0);
            pending_valid_out   <= hold_valid;
            pending_pos_out     <= hold_lane;
            new_pending_out     <= new_start;
            new_pending_pos_out <= new_lane;
        end
    end

    // a new start within the ranked slots sits on a rising lane of its word
    a_new_start_rising : assert property (@(posedge clk) disable iff (!rst_n)
        valid_in && new_start && (new_rank < cross_cnt_t'(MAX_PAIRS))
            |-> rise_mask[new_lane]);

endmodule

//--- verilog/pair_builder.sv
`timescale 1ns/100ps

module pair_builder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,
    input  pulse_pair_pkg::pair_lanes_t          rise_lanes,
    input  pulse_pair_pkg::pair_lanes_t          fall_lanes,
    input  pulse_pair_pkg::cross_cnt_t           rise_cnt,
    input  pulse_pair_pkg::cross_cnt_t           fall_cnt,
    input  logic                                 hold_valid,
    input  pulse_pair_pkg::lane_idx_t            hold_lane,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_valid,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_a,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_b,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_cross_cycle,
    output pulse_pair_pkg::cross_cnt_t           total_pairs,
    output logic                                 valid_out
);
    import pulse_pair_pkg::*;

    logic [MAX_PAIRS-1:0] valid_c;
    logic [MAX_PAIRS-1:0] cross_c;
    pair_lanes_t          pos_a_c;
    cross_cnt_t           open_cnt;
    cross_cnt_t           pairs_c;

    logic [MAX_PAIRS-1:0] pair_valid_s3;
    logic [MAX_PAIRS-1:0] cross_s3;
    pair_lanes_t          pos_a_s3;
    pair_lanes_t          pos_b_s3;
    cross_cnt_t           total_s3;
    logic                 valid_s3;

    // ------------------------------------------------------------------------
    // stage 3 rank matching
    // ------------------------------------------------------------------------
    assign open_cnt = rise_cnt + cross_cnt_t'(hold_valid);
    assign pairs_c  = (open_cnt < fall_cnt) ? open_cnt : fall_cnt;

    always_comb begin
        valid_c = '0;
        cross_c = '0;
        pos_a_c = rise_lanes;
        if (hold_valid) begin
            // held start takes the first end and the rest shift one rank
            pos_a_c[0] = hold_lane;
            valid_c[0] = (fall_cnt != '0);
            cross_c[0] = (fall_cnt != '0);
            for (int k = 1; k < MAX_PAIRS; k++) begin
                pos_a_c[k] = rise_lanes[k-1];
                valid_c[k] = (rise_cnt >= cross_cnt_t'(k)) && (fall_cnt > cross_cnt_t'(k));
            end
        end else begin
            for (int k = 0; k < MAX_PAIRS; k++) begin
                valid_c[k] = (rise_cnt > cross_cnt_t'(k)) && (fall_cnt > cross_cnt_t'(k));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s3      <= 1'b0;
            pair_valid_s3 <= '0;
            cross_s3      <= '0;
            total_s3      <= '0;
        end else begin
            valid_s3      <= valid_in;
            pair_valid_s3 <= valid_c;
            cross_s3      <= cross_c;
            total_s3      <= pairs_c;
        end
    end

    // end lanes never shift so falling rank k always lands in slot k
    always_ff @(posedge clk) begin
        pos_a_s3 <= pos_a_c;
        pos_b_s3 <= fall_lanes;
    end

    // ------------------------------------------------------------------------
    // stage 4 output registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out        <= 1'b0;
            pair_valid       <= '0;
            pair_cross_cycle <= '0;
            total_pairs      <= '0;
        end else begin
            valid_out        <= valid_s3;
            pair_valid       <= pair_valid_s3;
            pair_cross_cycle <= cross_s3;
            total_pairs      <= total_s3;
        end
    end

    always_ff @(posedge clk) begin
        pair_pos_a <= pos_a_s3;
        pair_pos_b <= pos_b_s3;
    end

    // valid slots fill up from slot 0 with no gaps
    a_valid_contiguous : assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> ((pair_valid & (pair_valid + 1'b1)) == '0));

    // only slot 0 closes a start from an earlier word and that pair is counted
    a_cross_slot0 : assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (pair_cross_cycle[MAX_PAIRS-1:1] == '0)
                      && (!pair_cross_cycle[0] || (total_pairs != '0)));

endmodule

//--- verilog/pair_pipeline.sv
`timescale 1ns/100ps

module pair_pipeline (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,
    input  pulse_pair_pkg::lane_mask_t           rise_mask,
    input  pulse_pair_pkg::lane_mask_t           fall_mask,
    input  pulse_pair_pkg::cross_cnt_t           rise_cnt,
    input  pulse_pair_pkg::cross_cnt_t           fall_cnt,
    input  logic                                 hold_valid,
    input  pulse_pair_pkg::lane_idx_t            hold_lane,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_valid,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_a,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_b,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_cross_cycle,
    output pulse_pair_pkg::cross_cnt_t           total_pairs,
    output logic                                 valid_out
);
    import pulse_pair_pkg::*;

    // ------------------------------------------------------------------------
    // stage 1: word and pending snapshot
    // ------------------------------------------------------------------------
    lane_mask_t rise_mask_s1;
    lane_mask_t fall_mask_s1;
    cross_cnt_t rise_cnt_s1;
    cross_cnt_t fall_cnt_s1;
    logic       hold_valid_s1;
    lane_idx_t  hold_lane_s1;
    logic       valid_s1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1      <= 1'b0;
            rise_cnt_s1   <= '0;
            fall_cnt_s1   <= '0;
            hold_valid_s1 <= 1'b0;
        end else begin
            valid_s1      <= valid_in;
            rise_cnt_s1   <= rise_cnt;
            fall_cnt_s1   <= fall_cnt;
            // pending as it was before this word
            hold_valid_s1 <= hold_valid;
        end
    end

    always_ff @(posedge clk) begin
        rise_mask_s1 <= rise_mask;
        fall_mask_s1 <= fall_mask;
        hold_lane_s1 <= hold_lane;
    end

    // ------------------------------------------------------------------------
    // stage 2: ranked lanes of both directions
    // ------------------------------------------------------------------------
    pair_lanes_t rise_lanes;
    pair_lanes_t fall_lanes;
    pair_lanes_t rise_lanes_s2;
    pair_lanes_t fall_lanes_s2;
    cross_cnt_t  rise_cnt_s2;
    cross_cnt_t  fall_cnt_s2;
    logic        hold_valid_s2;
    lane_idx_t   hold_lane_s2;
    logic        valid_s2;

    rank_extract u_rise_rank (
        .mask  (rise_mask_s1),
        .lanes (rise_lanes)
    );

    rank_extract u_fall_rank (
        .mask  (fall_mask_s1),
        .lanes (fall_lanes)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s2      <= 1'b0;
            rise_cnt_s2   <= '0;
            fall_cnt_s2   <= '0;
            hold_valid_s2 <= 1'b0;
        end else begin
            valid_s2      <= valid_s1;
            rise_cnt_s2   <= rise_cnt_s1;
            fall_cnt_s2   <= fall_cnt_s1;
            hold_valid_s2 <= hold_valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        rise_lanes_s2 <= rise_lanes;
        fall_lanes_s2 <= fall_lanes;
        hold_lane_s2  <= hold_lane_s1;
    end

    // stages 3 and 4
    pair_builder u_builder (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_s2),
        .rise_lanes       (rise_lanes_s2),
        .fall_lanes       (fall_lanes_s2),
        .rise_cnt         (rise_cnt_s2),
        .fall_cnt         (fall_cnt_s2),
        .hold_valid       (hold_valid_s2),
        .hold_lane        (hold_lane_s2),
        .pair_valid       (pair_valid),
        .pair_pos_a       (pair_pos_a),
        .pair_pos_b       (pair_pos_b),
        .pair_cross_cycle (pair_cross_cycle),
        .total_pairs      (total_pairs),
        .valid_out        (valid_out)
    );

endmodule

//--- verilog/zero_cross_pairer.sv
`timescale 1ns/100ps

module zero_cross_pairer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,
    input  pulse_pair_pkg::lane_mask_t           zero_mask,
    input  pulse_pair_pkg::lane_mask_t           zero_direction,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_valid,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_a,
    output pulse_pair_pkg::pair_lanes_t          pair_pos_b,
    output logic [pulse_pair_pkg::MAX_PAIRS-1:0] pair_cross_cycle,
    output pulse_pair_pkg::cross_cnt_t           total_pairs,
    output logic                                 valid_out,
    output logic                                 pending_valid_out,
    output pulse_pair_pkg::lane_idx_t            pending_pos_out,
    output logic                                 new_pending_out,
    output pulse_pair_pkg::lane_idx_t            new_pending_pos_out
);
    import pulse_pair_pkg::*;

    lane_mask_t rise_mask;
    lane_mask_t fall_mask;
    cross_cnt_t rise_cnt;
    cross_cnt_t fall_cnt;
    logic       hold_valid;
    lane_idx_t  hold_lane;

    crossing_count u_count (
        .zero_mask      (zero_mask),
        .zero_direction (zero_direction),
        .rise_mask      (rise_mask),
        .fall_mask      (fall_mask),
        .rise_cnt       (rise_cnt),
        .fall_cnt       (fall_cnt)
    );

    // ------------------------------------------------------------------------
    // fast path, one cycle
    // ------------------------------------------------------------------------
    pending_tracker u_pending (
        .clk                 (clk),
        .rst_n               (rst_n),
        .valid_in            (valid_in),
        .rise_mask           (rise_mask),
        .rise_cnt            (rise_cnt),
        .fall_cnt            (fall_cnt),
        .hold_valid          (hold_valid),
        .hold_lane           (hold_lane),
        .pending_valid_out   (pending_valid_out),
        .pending_pos_out     (pending_pos_out),
        .new_pending_out     (new_pending_out),
        .new_pending_pos_out (new_pending_pos_out)
    );

    // ------------------------------------------------------------------------
    // slow path, four stages
    // ------------------------------------------------------------------------
    pair_pipeline u_pairs (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_in),
        .rise_mask        (rise_mask),
        .fall_mask        (fall_mask),
        .rise_cnt         (rise_cnt),
        .fall_cnt         (fall_cnt),
        .hold_valid       (hold_valid),
        .hold_lane        (hold_lane),
        .pair_valid       (pair_valid),
        .pair_pos_a       (pair_pos_a),
        .pair_pos_b       (pair_pos_b),
        .pair_cross_cycle (pair_cross_cycle),
        .total_pairs      (total_pairs),
        .valid_out        (valid_out)
    );

endmodule

//--- test/tb_zero_cross_pairer.sv
`timescale 1ns/100ps

module tb_zero_cross_pairer;
    import pulse_pair_pkg::*;

    localparam int DRAIN_LIMIT  = 16;
    localparam int RANDOM_WORDS = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 valid_in;
    lane_mask_t           zero_mask;
    lane_mask_t           zero_direction;
    logic [MAX_PAIRS-1:0] pair_valid;
    pair_lanes_t          pair_pos_a;
    pair_lanes_t          pair_pos_b;
    logic [MAX_PAIRS-1:0] pair_cross_cycle;
    cross_cnt_t           total_pairs;
    logic                 valid_out;
    logic                 pending_valid_out;
    lane_idx_t            pending_pos_out;
    logic                 new_pending_out;
    lane_idx_t            new_pending_pos_out;

    // reference model pending state
    logic pend_v;
    int   pend_lane;

    // fast outputs expected after the last word
    logic fast_pend_v;
    int   fast_pend_pos;
    logic fast_new_v;
    int   fast_new_pos;

    // words in flight through the slow path
    string                exp_name[$];
    int                   exp_cycle[$];
    logic [MAX_PAIRS-1:0] exp_valid[$];
    logic [MAX_PAIRS-1:0] exp_cross[$];
    pair_lanes_t          exp_a[$];
    pair_lanes_t          exp_b[$];
    int                   exp_total[$];

    int cycle_cnt = 0;
    int check_cnt;
    int err_cnt;

    zero_cross_pairer DUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .valid_in            (valid_in),
        .zero_mask           (zero_mask),
        .zero_direction      (zero_direction),
        .pair_valid          (pair_valid),
        .pair_pos_a          (pair_pos_a),
        .pair_pos_b          (pair_pos_b),
        .pair_cross_cycle    (pair_cross_cycle),
        .total_pairs         (total_pairs),
        .valid_out           (valid_out),
        .pending_valid_out   (pending_valid_out),
        .pending_pos_out     (pending_pos_out),
        .new_pending_out     (new_pending_out),
        .new_pending_pos_out (new_pending_pos_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------------------
    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_fast(input string name);
        compare_value({name, " pending_valid_out"}, 32'(fast_pend_v), 32'(pending_valid_out));
        if (fast_pend_v) begin
            compare_value({name, " pending_pos_out"}, fast_pend_pos, 32'(pending_pos_out));
        end
        compare_value({name, " new_pending_out"}, 32'(fast_new_v), 32'(new_pending_out));
        if (fast_new_v) begin
            compare_value({name, " new_pending_pos_out"}, fast_new_pos,
                          32'(new_pending_pos_out));
        end
    endtask

    // one slow-path result, taken in the middle of the cycle
    task automatic check_result();
        string                name;
        int                   issued;
        logic [MAX_PAIRS-1:0] ev;
        pair_lanes_t          ea;
        pair_lanes_t          eb;

        if (exp_name.size() == 0) begin
            err_cnt++;
            $display("valid_out was raised while no word was in flight");
        end else begin
            name   = exp_name.pop_front();
            issued = exp_cycle.pop_front();
            ev     = exp_valid.pop_front();
            ea     = exp_a.pop_front();
            eb     = exp_b.pop_front();
            compare_value({name, " latency"}, PAIR_LATENCY, cycle_cnt - issued);
            compare_value({name, " pair_valid"}, 32'(ev), 32'(pair_valid));
            compare_value({name, " pair_cross_cycle"}, 32'(exp_cross.pop_front()),
                          32'(pair_cross_cycle));
            compare_value({name, " total_pairs"}, exp_total.pop_front(), 32'(total_pairs));
            // lanes of invalid slots are don't care
            for (int k = 0; k < MAX_PAIRS; k++) begin
                if (ev[k]) begin
                    compare_value($sformatf("%s start lane %0d", name, k), 32'(ea[k]),
                                  32'(pair_pos_a[k]));
                    compare_value($sformatf("%s end lane %0d", name, k), 32'(eb[k]),
                                  32'(pair_pos_b[k]));
                end
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && valid_out) begin
                check_result();
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------------------------------
    task automatic send_word(input string name, input lane_mask_t zmask,
                             input lane_mask_t zdir);
        int                   rise_pos[NUM_LANES];
        int                   fall_pos[NUM_LANES];
        int                   r_cnt;
        int                   f_cnt;
        int                   p;
        logic                 new_v;
        int                   new_lane;
        logic [MAX_PAIRS-1:0] ev;
        logic [MAX_PAIRS-1:0] ec;
        pair_lanes_t          ea;
        pair_lanes_t          eb;

        r_cnt    = 0;
        f_cnt    = 0;
        new_lane = 0;
        ev       = '0;
        ec       = '0;
        ea       = '0;
        eb       = '0;
        // rank 0 is the lowest lane of each direction
        for (int i = 0; i < NUM_LANES; i++) begin
            rise_pos[i] = 0;
            fall_pos[i] = 0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (zmask[i] && zdir[i]) begin
                rise_pos[r_cnt] = i;
                r_cnt++;
            end else if (zmask[i]) begin
                fall_pos[f_cnt] = i;
                f_cnt++;
            end
        end
        p = pend_v ? 1 : 0;
        for (int k = 0; k < MAX_PAIRS; k++) begin
            if (p == 0 && r_cnt > k && f_cnt > k) begin
                ev[k] = 1'b1;
                ea[k] = lane_idx_t'(rise_pos[k]);
                eb[k] = lane_idx_t'(fall_pos[k]);
            end else if (p == 1 && k == 0 && f_cnt > 0) begin
                ev[0] = 1'b1;
                ec[0] = 1'b1;
                ea[0] = lane_idx_t'(pend_lane);
                eb[0] = lane_idx_t'(fall_pos[0]);
            end else if (p == 1 && k > 0 && r_cnt >= k && f_cnt >= k + 1) begin
                ev[k] = 1'b1;
                ea[k] = lane_idx_t'(rise_pos[k-1]);
                eb[k] = lane_idx_t'(fall_pos[k]);
            end
        end
        new_v = (r_cnt + p > f_cnt) && (r_cnt != 0);
        if (new_v && f_cnt >= p) begin
            new_lane = rise_pos[f_cnt - p];
        end

        zero_mask      = zmask;
        zero_direction = zdir;
        valid_in       = 1'b1;
        exp_name.push_back(name);
        exp_cycle.push_back(cycle_cnt);
        exp_valid.push_back(ev);
        exp_cross.push_back(ec);
        exp_a.push_back(ea);
        exp_b.push_back(eb);
        exp_total.push_back((r_cnt + p < f_cnt) ? r_cnt + p : f_cnt);

        fast_pend_v   = pend_v;
        fast_pend_pos = pend_lane;
        fast_new_v    = new_v;
        fast_new_pos  = new_lane;
        pend_v        = new_v || (p == 1 && f_cnt == 0);
        if (new_v) begin
            pend_lane = new_lane;
        end

        @(posedge clk);
        #1;
        check_fast(name);
    endtask

    // masks toggle while valid_in is low and must be ignored
    task automatic idle_cycles(input string name, input int cycles);
        valid_in = 1'b0;
        repeat (cycles) begin
            zero_mask      = lane_mask_t'($urandom);
            zero_direction = lane_mask_t'($urandom);
            @(posedge clk);
            #1;
            check_fast(name);
        end
    endtask

    task automatic wait_drain(input string name);
        int waited;

        valid_in = 1'b0;
        waited   = 0;
        while (exp_name.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_name.size() != 0) begin
            err_cnt++;
            $display("%s: timed out, %0d words never reached valid_out", name, exp_name.size());
            exp_name.delete();
            exp_cycle.delete();
            exp_valid.delete();
            exp_cross.delete();
            exp_a.delete();
            exp_b.delete();
            exp_total.delete();
        end
    endtask

    task automatic random_word(output lane_mask_t zmask, output lane_mask_t zdir);
        int r_left;
        int f_left;
        int pick;

        zmask  = '0;
        zdir   = '0;
        r_left = MAX_PAIRS;
        f_left = MAX_PAIRS;
        for (int i = 0; i < NUM_LANES; i++) begin
            pick = int'($urandom_range(3));
            if (pick == 2 && r_left > 0) begin
                zmask[i] = 1'b1;
                zdir[i]  = 1'b1;
                r_left--;
            end else if (pick == 3 && f_left > 0) begin
                zmask[i] = 1'b1;
                f_left--;
            end
        end
        // a held start with no falling edge takes no further rising edge
        if (pend_v && f_left == MAX_PAIRS) begin
            zmask = zmask & ~zdir;
        end
        zdir = zdir | (lane_mask_t'($urandom) & ~zmask);
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %-18s %0d errors", name, err_cnt - err_start);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_values();
        int err_start;

        err_start = err_cnt;
        compare_value("reset valid_out", 0, 32'(valid_out));
        compare_value("reset pair_valid", 0, 32'(pair_valid));
        compare_value("reset pair_cross_cycle", 0, 32'(pair_cross_cycle));
        compare_value("reset total_pairs", 0, 32'(total_pairs));
        compare_value("reset pending_valid_out", 0, 32'(pending_valid_out));
        compare_value("reset new_pending_out", 0, 32'(new_pending_out));
        report_test("reset state", err_start);
    endtask

    task automatic in_word_pairs();
        int err_start;

        err_start = err_cnt;
        // rising 1 5 9, falling 3 7 12
        send_word("in-word", 16'h12AA, 16'h0222);
        wait_drain("in-word");
        report_test("in-word pairs", err_start);
    endtask

    task automatic cross_word_pulse();
        int err_start;

        err_start = err_cnt;
        // rising 2 6 10, falling 4 8, lane 10 stays open
        send_word("cross-word A", 16'h0554, 16'h0444);
        compare_value("cross-word new start lane", 10, 32'(new_pending_pos_out));
        // falling 1 9, rising 5
        send_word("cross-word B", 16'h0222, 16'h0020);
        wait_drain("cross-word");
        report_test("cross-word pulse", err_start);
    endtask

    task automatic held_start();
        int err_start;

        err_start = err_cnt;
        send_word("held open", 16'h0010, 16'h0010);
        send_word("held empty 1", 16'h0000, 16'hFFFF);
        send_word("held empty 2", 16'h0000, 16'h0000);
        idle_cycles("held idle", 5);
        send_word("held empty 3", 16'h0000, 16'h5A5A);
        // falling 6 11, rising 8
        send_word("held close", 16'h0940, 16'h0100);
        wait_drain("held start");
        report_test("held start", err_start);
    endtask

    task automatic random_words();
        int         err_start;
        lane_mask_t zmask;
        lane_mask_t zdir;

        err_start = err_cnt;
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            random_word(zmask, zdir);
            send_word($sformatf("random %0d", i), zmask, zdir);
        end
        wait_drain("random");
        report_test("random words", err_start);
    endtask

    initial begin
        void'($urandom(32'h434b_2aa5));
        rst_n          = 1'b0;
        valid_in       = 1'b0;
        zero_mask      = '0;
        zero_direction = '0;
        pend_v         = 1'b0;
        pend_lane      = 0;
        fast_pend_v    = 1'b0;
        fast_pend_pos  = 0;
        fast_new_v     = 1'b0;
        fast_new_pos   = 0;
        check_cnt      = 0;
        err_cnt        = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_values();
        in_word_pairs();
        cross_word_pulse();
        held_start();
        random_words();

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/pulse_pair_pkg.sv
verilog/crossing_count.sv
verilog/rank_extract.sv
verilog/pending_tracker.sv
verilog/pair_builder.sv
verilog/pair_pipeline.sv
verilog/zero_cross_pairer.sv
test/tb_zero_cross_pairer.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_zero_cross_pairer \
    -f flist.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
[ "$run_status" -eq 0 ] || exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
